/* hw/lsq_pkg.sv */
//////////////////////////////
// load/store unit shared types
// word, data, ROB index and tag widths
// plus the arbiter owner encoding
//////////////////////////////

package lsq_pkg;

	// word address
	typedef logic [15:0] addr_t;

	// data word
	typedef logic [31:0] data_t;

	// reorder-buffer index of a load
	typedef logic [4:0] rob_idx_t;

	// destination physical register tag
	typedef logic [5:0] prf_tag_t;

	// requester that received the last memory grant
	typedef enum logic {
		OWN_STORE,
		OWN_LOAD
	} arb_owner_e;

endpackage

/* hw/store_queue.sv */
//////////////////////////////
// store queue
// program-order allocation, execute writes,
// load age check, store-to-load forwarding
// and drain of retired stores to memory
//////////////////////////////

module store_queue #(
	parameter int SQ_ENT = 8
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      disp_st_i,
	input  logic                      st_vld_i,
	input  logic [$clog2(SQ_ENT):0]   st_idx_i,
	input  lsq_pkg::addr_t            st_addr_i,
	input  lsq_pkg::data_t            st_data_i,
	input  logic                      st_retire_i,
	input  logic [$clog2(SQ_ENT):0]   rs_ld_pos_i,
	input  lsq_pkg::addr_t            ld_addr_i,
	input  logic [$clog2(SQ_ENT):0]   ld_sq_pos_i,
	input  logic                      wr_gnt_i,
	output logic [$clog2(SQ_ENT):0]   sq_tail_o,
	output logic                      sq_full_o,
	output logic                      ld_issue_ok_o,
	output logic                      fwd_hit_o,
	output lsq_pkg::data_t            fwd_data_o,
	output logic                      wr_req_o,
	output lsq_pkg::addr_t            wr_addr_o,
	output lsq_pkg::data_t            wr_data_o
);

	localparam int IW = $clog2(SQ_ENT);

	// position is the slot index with a wrap bit on top
	typedef logic [IW:0] sq_pos_t;
	typedef logic [IW-1:0] sq_slot_t;

	sq_pos_t           head_r;
	sq_pos_t           tail_r;
	sq_pos_t           cmt_r;
	lsq_pkg::addr_t    addr_r [SQ_ENT];
	lsq_pkg::data_t    data_r [SQ_ENT];
	logic [SQ_ENT-1:0] addr_vld_r;

	sq_slot_t          head_slot;
	sq_slot_t          tail_slot;
	sq_slot_t          st_slot;
	sq_pos_t           rs_span;
	sq_pos_t           ld_span;
	logic              drain;

	assign head_slot = head_r[IW-1:0];
	assign tail_slot = tail_r[IW-1:0];
	assign st_slot   = st_idx_i[IW-1:0];

	assign sq_tail_o = tail_r;
	assign sq_full_o = (head_slot == tail_slot) && (head_r[IW] != tail_r[IW]);

	// committed but not yet written entries sit between head and commit
	assign wr_req_o  = (head_r != cmt_r);
	assign wr_addr_o = addr_r[head_slot];
	assign wr_data_o = data_r[head_slot];
	assign drain     = wr_req_o && wr_gnt_i;

	// number of stores older than the load
	assign rs_span = rs_ld_pos_i - head_r;
	assign ld_span = ld_sq_pos_i - head_r;

	always_comb begin
		sq_slot_t slot;
		ld_issue_ok_o = 1'b1;
		for (int k = 0; k < SQ_ENT; k++) begin
			slot = head_slot + sq_slot_t'(k);
			if ((sq_pos_t'(k) < rs_span) && !addr_vld_r[slot])
				ld_issue_ok_o = 1'b0;
		end
	end

	// scan from oldest to youngest, last match wins
	always_comb begin
		sq_slot_t slot;
		fwd_hit_o  = 1'b0;
		fwd_data_o = '0;
		for (int k = 0; k < SQ_ENT; k++) begin
			slot = head_slot + sq_slot_t'(k);
			if ((sq_pos_t'(k) < ld_span) && addr_vld_r[slot] &&
					(addr_r[slot] == ld_addr_i)) begin
				fwd_hit_o  = 1'b1;
				fwd_data_o = data_r[slot];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r     <= '0;
			tail_r     <= '0;
			cmt_r      <= '0;
			addr_vld_r <= '0;
		end else begin
			// a fresh entry has no address yet
			if (disp_st_i) begin
				tail_r                <= tail_r + 1'b1;
				addr_vld_r[tail_slot] <= 1'b0;
			end
			if (st_retire_i)
				cmt_r <= cmt_r + 1'b1;
			if (drain)
				head_r <= head_r + 1'b1;
			if (st_vld_i)
				addr_vld_r[st_slot] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (st_vld_i) begin
			addr_r[st_slot] <= st_addr_i;
			data_r[st_slot] <= st_data_i;
		end
	end

endmodule

/* hw/load_queue.sv */
//////////////////////////////
// load miss queue
// in-order read issue, fill by response
// address, completion from the head
//////////////////////////////

module load_queue #(
	parameter int LQ_ENT = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                alloc_i,
	input  lsq_pkg::addr_t      ld_addr_i,
	input  lsq_pkg::rob_idx_t   ld_rob_idx_i,
	input  lsq_pkg::prf_tag_t   ld_tag_i,
	input  logic                rd_gnt_i,
	input  logic                rsp_vld_i,
	input  lsq_pkg::addr_t      rsp_addr_i,
	input  lsq_pkg::data_t      rsp_data_i,
	input  logic                comp_free_i,
	output logic                lq_full_o,
	output logic                rd_req_o,
	output lsq_pkg::addr_t      rd_addr_o,
	output logic                head_vld_o,
	output lsq_pkg::data_t      head_data_o,
	output lsq_pkg::rob_idx_t   head_rob_idx_o,
	output lsq_pkg::prf_tag_t   head_tag_o
);

	localparam int IW = $clog2(LQ_ENT);

	typedef logic [IW:0] lq_pos_t;
	typedef logic [IW-1:0] lq_slot_t;

	lq_pos_t             head_r;
	lq_pos_t             iss_r;
	lq_pos_t             tail_r;
	lsq_pkg::addr_t      addr_r [LQ_ENT];
	lsq_pkg::data_t      data_r [LQ_ENT];
	lsq_pkg::rob_idx_t   rob_r [LQ_ENT];
	lsq_pkg::prf_tag_t   tag_r [LQ_ENT];
	logic [LQ_ENT-1:0]   rdy_r;

	lq_slot_t            head_slot;
	lq_slot_t            iss_slot;
	lq_slot_t            tail_slot;
	lq_pos_t             iss_span;
	logic [LQ_ENT-1:0]   fill;
	logic                pop;

	assign head_slot = head_r[IW-1:0];
	assign iss_slot  = iss_r[IW-1:0];
	assign tail_slot = tail_r[IW-1:0];

	assign lq_full_o = (head_slot == tail_slot) && (head_r[IW] != tail_r[IW]);

	// one read per entry, oldest unissued first
	assign rd_req_o  = (iss_r != tail_r);
	assign rd_addr_o = addr_r[iss_slot];

	assign head_vld_o     = (head_r != tail_r) && rdy_r[head_slot];
	assign head_data_o    = data_r[head_slot];
	assign head_rob_idx_o = rob_r[head_slot];
	assign head_tag_o     = tag_r[head_slot];
	assign pop            = head_vld_o && comp_free_i;

	assign iss_span = iss_r - head_r;

	// every issued entry still waiting on this address takes the data
	always_comb begin
		lq_slot_t slot;
		fill = '0;
		for (int k = 0; k < LQ_ENT; k++) begin
			slot = head_slot + lq_slot_t'(k);
			if (rsp_vld_i && (lq_pos_t'(k) < iss_span) && !rdy_r[slot] &&
					(addr_r[slot] == rsp_addr_i))
				fill[slot] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			iss_r  <= '0;
			tail_r <= '0;
			rdy_r  <= '0;
		end else begin
			if (alloc_i) begin
				tail_r           <= tail_r + 1'b1;
				rdy_r[tail_slot] <= 1'b0;
			end
			if (rd_gnt_i)
				iss_r <= iss_r + 1'b1;
			if (pop)
				head_r <= head_r + 1'b1;
			for (int k = 0; k < LQ_ENT; k++) begin
				if (fill[k])
					rdy_r[k] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_i) begin
			addr_r[tail_slot] <= ld_addr_i;
			rob_r[tail_slot]  <= ld_rob_idx_i;
			tag_r[tail_slot]  <= ld_tag_i;
		end
		for (int k = 0; k < LQ_ENT; k++) begin
			if (fill[k])
				data_r[k] <= rsp_data_i;
		end
	end

endmodule

/* hw/mem_arbiter.sv */
//////////////////////////////
// data memory port arbiter
// round robin between store drain
// and load read requests
//////////////////////////////

module mem_arbiter (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_req_i,
	input  lsq_pkg::addr_t   wr_addr_i,
	input  lsq_pkg::data_t   wr_data_i,
	input  logic             rd_req_i,
	input  lsq_pkg::addr_t   rd_addr_i,
	output logic             wr_gnt_o,
	output logic             rd_gnt_o,
	output logic             mem_req_o,
	output logic             mem_we_o,
	output lsq_pkg::addr_t   mem_addr_o,
	output lsq_pkg::data_t   mem_wdata_o
);

	lsq_pkg::arb_owner_e last_r;

	// on a tie the side not granted last wins
	assign wr_gnt_o = wr_req_i && (!rd_req_i || (last_r == lsq_pkg::OWN_LOAD));
	assign rd_gnt_o = rd_req_i && !wr_gnt_o;

	assign mem_req_o   = wr_gnt_o || rd_gnt_o;
	assign mem_we_o    = wr_gnt_o;
	assign mem_addr_o  = wr_gnt_o ? wr_addr_i : rd_addr_i;
	assign mem_wdata_o = wr_data_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_r <= lsq_pkg::OWN_LOAD;
		end else if (wr_gnt_o) begin
			last_r <= lsq_pkg::OWN_STORE;
		end else if (rd_gnt_o) begin
			last_r <= lsq_pkg::OWN_LOAD;
		end
	end

endmodule

/* hw/data_mem.sv */
//////////////////////////////
// data memory
// word storage, writes at the grant edge,
// reads return address and data after
// a fixed pipeline latency
//////////////////////////////

module data_mem #(
	parameter int MEM_AW  = 8,
	parameter int MEM_LAT = 3
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             mem_req_i,
	input  logic             mem_we_i,
	input  lsq_pkg::addr_t   mem_addr_i,
	input  lsq_pkg::data_t   mem_wdata_i,
	output logic             rsp_vld_o,
	output lsq_pkg::addr_t   rsp_addr_o,
	output lsq_pkg::data_t   rsp_data_o
);

	lsq_pkg::data_t     mem_r [2**MEM_AW];
	logic [MEM_LAT-1:0] vld_r;
	lsq_pkg::addr_t     addr_r [MEM_LAT];
	lsq_pkg::data_t     data_r [MEM_LAT];

	logic [MEM_AW-1:0]  idx;
	logic               rd_en;

	// only the low address bits select a word
	assign idx   = mem_addr_i[MEM_AW-1:0];
	assign rd_en = mem_req_i && !mem_we_i;

	always_ff @(posedge clk) begin
		if (mem_req_i && mem_we_i)
			mem_r[idx] <= mem_wdata_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r <= '0;
		end else begin
			vld_r[0] <= rd_en;
			for (int s = 1; s < MEM_LAT; s++)
				vld_r[s] <= vld_r[s-1];
		end
	end

	// stage 0 samples the array in the grant cycle
	always_ff @(posedge clk) begin
		addr_r[0] <= mem_addr_i;
		data_r[0] <= mem_r[idx];
		for (int s = 1; s < MEM_LAT; s++) begin
			addr_r[s] <= addr_r[s-1];
			data_r[s] <= data_r[s-1];
		end
	end

	assign rsp_vld_o  = vld_r[MEM_LAT-1];
	assign rsp_addr_o = addr_r[MEM_LAT-1];
	assign rsp_data_o = data_r[MEM_LAT-1];

endmodule

/* hw/lsq_top.sv */
//////////////////////////////
// load/store unit top
// store queue, load miss queue, memory
// arbiter and data memory, with one
// merged load completion port
//////////////////////////////

module lsq_top #(
	parameter int SQ_ENT  = 8,
	parameter int LQ_ENT  = 4,
	parameter int MEM_AW  = 8,
	parameter int MEM_LAT = 3
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      disp_st_i,
	input  logic                      st_vld_i,
	input  logic [$clog2(SQ_ENT):0]   st_idx_i,
	input  lsq_pkg::addr_t            st_addr_i,
	input  lsq_pkg::data_t            st_data_i,
	input  logic                      st_retire_i,
	input  logic [$clog2(SQ_ENT):0]   rs_ld_pos_i,
	input  logic                      ld_vld_i,
	input  lsq_pkg::addr_t            ld_addr_i,
	input  lsq_pkg::rob_idx_t         ld_rob_idx_i,
	input  lsq_pkg::prf_tag_t         ld_tag_i,
	input  logic [$clog2(SQ_ENT):0]   ld_sq_pos_i,
	output logic [$clog2(SQ_ENT):0]   sq_tail_o,
	output logic                      sq_full_o,
	output logic                      lq_full_o,
	output logic                      ld_issue_ok_o,
	output logic                      comp_vld_o,
	output lsq_pkg::data_t            comp_data_o,
	output lsq_pkg::rob_idx_t         comp_rob_idx_o,
	output lsq_pkg::prf_tag_t         comp_tag_o
);

	logic fwd_hit, wr_req, wr_gnt, rd_req, rd_gnt;
	logic mem_req, mem_we, rsp_vld, head_vld, comp_free;
	lsq_pkg::data_t    fwd_data, wr_data, mem_wdata, rsp_data, head_data;
	lsq_pkg::addr_t    wr_addr, rd_addr, mem_addr, rsp_addr;
	lsq_pkg::rob_idx_t head_rob_idx;
	lsq_pkg::prf_tag_t head_tag;

	// forwarded load, held one cycle for the completion port
	logic              fwd_vld_r;
	lsq_pkg::data_t    fwd_data_r;
	lsq_pkg::rob_idx_t fwd_rob_r;
	lsq_pkg::prf_tag_t fwd_tag_r;

	store_queue #(.SQ_ENT(SQ_ENT)) store_queue_i (
		.clk(clk), .rst(rst), .disp_st_i(disp_st_i), .st_vld_i(st_vld_i),
		.st_idx_i(st_idx_i), .st_addr_i(st_addr_i), .st_data_i(st_data_i),
		.st_retire_i(st_retire_i), .rs_ld_pos_i(rs_ld_pos_i), .ld_addr_i(ld_addr_i),
		.ld_sq_pos_i(ld_sq_pos_i), .wr_gnt_i(wr_gnt), .sq_tail_o(sq_tail_o),
		.sq_full_o(sq_full_o), .ld_issue_ok_o(ld_issue_ok_o), .fwd_hit_o(fwd_hit),
		.fwd_data_o(fwd_data), .wr_req_o(wr_req), .wr_addr_o(wr_addr),
		.wr_data_o(wr_data)
	);

	load_queue #(.LQ_ENT(LQ_ENT)) load_queue_i (
		.clk(clk), .rst(rst), .alloc_i(ld_vld_i && !fwd_hit), .ld_addr_i(ld_addr_i),
		.ld_rob_idx_i(ld_rob_idx_i), .ld_tag_i(ld_tag_i), .rd_gnt_i(rd_gnt),
		.rsp_vld_i(rsp_vld), .rsp_addr_i(rsp_addr), .rsp_data_i(rsp_data),
		.comp_free_i(comp_free), .lq_full_o(lq_full_o), .rd_req_o(rd_req),
		.rd_addr_o(rd_addr), .head_vld_o(head_vld), .head_data_o(head_data),
		.head_rob_idx_o(head_rob_idx), .head_tag_o(head_tag)
	);

	mem_arbiter mem_arbiter_i (
		.clk(clk), .rst(rst), .wr_req_i(wr_req), .wr_addr_i(wr_addr),
		.wr_data_i(wr_data), .rd_req_i(rd_req), .rd_addr_i(rd_addr),
		.wr_gnt_o(wr_gnt), .rd_gnt_o(rd_gnt), .mem_req_o(mem_req),
		.mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
	);

	data_mem #(.MEM_AW(MEM_AW), .MEM_LAT(MEM_LAT)) data_mem_i (
		.clk(clk), .rst(rst), .mem_req_i(mem_req), .mem_we_i(mem_we),
		.mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata), .rsp_vld_o(rsp_vld),
		.rsp_addr_o(rsp_addr), .rsp_data_o(rsp_data)
	);

	always_ff @(posedge clk) begin
		if (rst)
			fwd_vld_r <= 1'b0;
		else
			fwd_vld_r <= ld_vld_i && fwd_hit;
	end

	always_ff @(posedge clk) begin
		if (ld_vld_i) begin
			fwd_data_r <= fwd_data;
			fwd_rob_r  <= ld_rob_idx_i;
			fwd_tag_r  <= ld_tag_i;
		end
	end

	// a forward always takes the port, the miss head waits
	assign comp_free      = !fwd_vld_r;
	assign comp_vld_o     = fwd_vld_r || head_vld;
	assign comp_data_o    = fwd_vld_r ? fwd_data_r : head_data;
	assign comp_rob_idx_o = fwd_vld_r ? fwd_rob_r : head_rob_idx;
	assign comp_tag_o     = fwd_vld_r ? fwd_tag_r : head_tag;

endmodule

/* tests/tb_lsq_top.sv */
//////////////////////////////
// load/store unit testbench
// directed tests against a memory
// model and a completion scoreboard
//////////////////////////////

module tb_lsq_top;

	localparam int SQ_ENT     = 8;
	localparam int LQ_ENT     = 4;
	localparam int MEM_AW     = 8;
	localparam int MEM_LAT    = 3;
	localparam int CLK_P      = 4;
	localparam int PW         = $clog2(SQ_ENT) + 1;
	// rough cycle counts of the six tests
	localparam int TEST_CYC   = 10 + 60 + 60 + 30 + 60 + 80;
	localparam int WAIT_LIMIT = 16 * MEM_LAT + 32;

	typedef logic [PW-1:0] pos_t;
	typedef struct packed {
		lsq_pkg::data_t    data;
		lsq_pkg::rob_idx_t rob;
		lsq_pkg::prf_tag_t tag;
		logic [31:0]       due;
	} exp_t;

	logic              clk, rst;
	logic              disp_st_i, st_vld_i, st_retire_i, ld_vld_i;
	pos_t              st_idx_i, rs_ld_pos_i, ld_sq_pos_i, sq_tail_o;
	lsq_pkg::addr_t    st_addr_i, ld_addr_i;
	lsq_pkg::data_t    st_data_i, comp_data_o;
	lsq_pkg::rob_idx_t ld_rob_idx_i, comp_rob_idx_o;
	lsq_pkg::prf_tag_t ld_tag_i, comp_tag_o;
	logic              sq_full_o, lq_full_o, ld_issue_ok_o, comp_vld_o;

	// memory model and stores still held in the queue, oldest first
	lsq_pkg::data_t    mem_model [lsq_pkg::addr_t];
	pos_t              m_pos [$];
	lsq_pkg::addr_t    m_addr [$];
	lsq_pkg::data_t    m_data [$];
	logic              m_av [$];
	exp_t              fwd_q [$];
	exp_t              miss_q [$];

	integer            seed = 32'h200704a9;
	int                cyc = 0;
	int                errors = 0;
	int                checks = 0;
	lsq_pkg::rob_idx_t rob_ctr = '0;

	lsq_top #(
		.SQ_ENT(SQ_ENT), .LQ_ENT(LQ_ENT), .MEM_AW(MEM_AW), .MEM_LAT(MEM_LAT)
	) lsq_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_P / 2) clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic lsq_pkg::addr_t scratch_addr();
		return lsq_pkg::addr_t'(32'h80 + (next_rand() & 32'h3f));
	endfunction

	// youngest matching store among those dispatched before the load
	function automatic logic lookup_fwd(input pos_t ld_pos, input lsq_pkg::addr_t a,
			output lsq_pkg::data_t d);
		logic hit;
		logic older;
		hit   = 1'b0;
		older = 1'b1;
		d     = '0;
		for (int i = 0; i < m_pos.size(); i++) begin
			// the load sits just before the store that took its position
			if (m_pos[i] == ld_pos)
				older = 1'b0;
			if (older && m_av[i] && (m_addr[i] == a)) begin
				hit = 1'b1;
				d   = m_data[i];
			end
		end
		return hit;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic expect_level(input logic got, input logic want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR t=%0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic compare_comp(input exp_t e);
		checks++;
		if (comp_data_o !== e.data || comp_rob_idx_o !== e.rob || comp_tag_o !== e.tag) begin
			errors++;
			$display("ERROR t=%0t: got rob %0d tag %0d data %h, expected rob %0d tag %0d data %h",
				$time, comp_rob_idx_o, comp_tag_o, comp_data_o, e.rob, e.tag, e.data);
		end
	endtask

	// forwards are due on a fixed cycle, misses come in load order
	always @(negedge clk) begin
		exp_t e;
		if (!rst) begin
			if (fwd_q.size() != 0 && fwd_q[0].due == cyc) begin
				e = fwd_q.pop_front();
				if (!comp_vld_o) begin
					errors++;
					$display("ERROR t=%0t: forwarded load rob %0d did not complete", $time, e.rob);
				end else begin
					compare_comp(e);
				end
			end else if (comp_vld_o) begin
				if (miss_q.size() == 0) begin
					errors++;
					$display("ERROR t=%0t: unexpected completion rob %0d", $time, comp_rob_idx_o);
				end else begin
					compare_comp(miss_q.pop_front());
				end
			end
		end
	end

	task automatic dispatch_store();
		m_pos.push_back(sq_tail_o);
		m_addr.push_back('0);
		m_data.push_back('0);
		m_av.push_back(1'b0);
		disp_st_i = 1'b1;
		step();
		disp_st_i = 1'b0;
	endtask

	task automatic exec_store(input int i, input lsq_pkg::addr_t a, input lsq_pkg::data_t d);
		m_addr[i] = a;
		m_data[i] = d;
		m_av[i]   = 1'b1;
		st_vld_i  = 1'b1;
		st_idx_i  = m_pos[i];
		st_addr_i = a;
		st_data_i = d;
		step();
		st_vld_i  = 1'b0;
	endtask

	task automatic retire_store();
		mem_model[m_addr[0]] = m_data[0];
		st_retire_i = 1'b1;
		step();
		st_retire_i = 1'b0;
		// drain goes out the cycle after commit
		step();
		void'(m_pos.pop_front());
		void'(m_addr.pop_front());
		void'(m_data.pop_front());
		void'(m_av.pop_front());
	endtask

	task automatic flush_stores();
		while (m_pos.size() != 0) begin
			if (!m_av[0])
				exec_store(0, scratch_addr(), next_rand());
			retire_store();
		end
	endtask

	task automatic issue_load(input pos_t pos, input lsq_pkg::addr_t a);
		exp_t e;
		lsq_pkg::data_t d;
		int n;
		n = 0;
		rs_ld_pos_i = pos;
		@(negedge clk);
		while (!ld_issue_ok_o || lq_full_o) begin
			n++;
			if (n > WAIT_LIMIT) begin
				errors++;
				$display("load of address %h was never allowed to issue", a);
				break;
			end
			@(negedge clk);
		end
		step();
		e.rob = rob_ctr;
		e.tag = lsq_pkg::prf_tag_t'(next_rand());
		e.due = cyc + 1;
		rob_ctr++;
		ld_vld_i     = 1'b1;
		ld_addr_i    = a;
		ld_rob_idx_i = e.rob;
		ld_tag_i     = e.tag;
		ld_sq_pos_i  = pos;
		if (lookup_fwd(pos, a, d)) begin
			e.data = d;
			fwd_q.push_back(e);
		end else begin
			e.data = mem_model[a];
			miss_q.push_back(e);
		end
		step();
		ld_vld_i = 1'b0;
	endtask

	task automatic wait_loads();
		int n;
		n = 0;
		while (fwd_q.size() != 0 || miss_q.size() != 0) begin
			if (n == WAIT_LIMIT) begin
				errors++;
				$display("%0d loads still outstanding after %0d cycles",
					fwd_q.size() + miss_q.size(), n);
				fwd_q.delete();
				miss_q.delete();
			end else begin
				step();
				n++;
			end
		end
	endtask

	task automatic reset_state();
		@(negedge clk);
		expect_level(comp_vld_o, 1'b0, "comp_vld_o after reset");
		expect_level(sq_full_o, 1'b0, "sq_full_o after reset");
		expect_level(lq_full_o, 1'b0, "lq_full_o after reset");
		expect_level(sq_tail_o == '0, 1'b1, "sq_tail_o at zero after reset");
		step();
	endtask

	task automatic drain_then_load();
		for (int k = 0; k < LQ_ENT; k++) begin
			dispatch_store();
			exec_store(m_pos.size() - 1, lsq_pkg::addr_t'(32'h10 + k), next_rand());
			retire_store();
		end
		// two loads share one address
		issue_load(sq_tail_o, 16'h10);
		issue_load(sq_tail_o, 16'h10);
		issue_load(sq_tail_o, 16'h11);
		issue_load(sq_tail_o, 16'h13);
		wait_loads();
	endtask

	task automatic forwarding_cases();
		dispatch_store();
		dispatch_store();
		exec_store(0, 16'h40, next_rand());
		exec_store(1, 16'h40, next_rand());
		issue_load(sq_tail_o, 16'h40);
		// placed between the two stores, sees only the first
		issue_load(m_pos[1], 16'h40);
		// nothing matches, goes to memory
		issue_load(sq_tail_o, 16'h12);
		wait_loads();
		flush_stores();
	endtask

	task automatic issue_gate();
		dispatch_store();
		rs_ld_pos_i = sq_tail_o;
		@(negedge clk);
		expect_level(ld_issue_ok_o, 1'b0, "ld_issue_ok_o with an unknown older address");
		step();
		exec_store(0, 16'h41, next_rand());
		@(negedge clk);
		expect_level(ld_issue_ok_o, 1'b1, "ld_issue_ok_o after the store executed");
		step();
		issue_load(sq_tail_o, 16'h41);
		wait_loads();
		flush_stores();
	endtask

	task automatic full_flag();
		for (int k = 0; k < SQ_ENT; k++)
			dispatch_store();
		@(negedge clk);
		expect_level(sq_full_o, 1'b1, "sq_full_o with every entry allocated");
		step();
		exec_store(0, scratch_addr(), next_rand());
		retire_store();
		@(negedge clk);
		expect_level(sq_full_o, 1'b0, "sq_full_o after one drain");
		step();
		flush_stores();
	endtask

	task automatic random_misses();
		for (int k = 0; k < LQ_ENT; k++) begin
			dispatch_store();
			exec_store(m_pos.size() - 1, scratch_addr(), next_rand());
		end
		for (int k = 0; k < m_pos.size(); k++)
			mem_model[m_addr[k]] = m_data[k];
		// drains of the older stores compete with the load reads for the port
		fork
			begin
				st_retire_i = 1'b1;
				repeat (LQ_ENT) step();
				st_retire_i = 1'b0;
			end
			for (int k = 0; k < LQ_ENT; k++)
				issue_load(sq_tail_o, lsq_pkg::addr_t'(32'h10 + (next_rand() & 32'h3)));
		join
		wait_loads();
		// a duplicate completion would show up here
		repeat (4 * MEM_LAT) step();
		m_pos.delete();
		m_addr.delete();
		m_data.delete();
		m_av.delete();
	endtask

	initial begin
		rst          = 1'b1;
		disp_st_i    = 1'b0;
		st_vld_i     = 1'b0;
		st_idx_i     = '0;
		st_addr_i    = '0;
		st_data_i    = '0;
		st_retire_i  = 1'b0;
		rs_ld_pos_i  = '0;
		ld_vld_i     = 1'b0;
		ld_addr_i    = '0;
		ld_rob_idx_i = '0;
		ld_tag_i     = '0;
		ld_sq_pos_i  = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_state();
		drain_then_load();
		forwarding_cases();
		issue_gate();
		full_flag();
		random_misses();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#((TEST_CYC + 100) * MEM_LAT * CLK_P);
		$display("watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* filelist.f */
hw/lsq_pkg.sv
hw/store_queue.sv
hw/load_queue.sv
hw/mem_arbiter.sv
hw/data_mem.sv
hw/lsq_top.sv
tests/tb_lsq_top.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - files:
      - hw/lsq_pkg.sv
      - hw/store_queue.sv
      - hw/load_queue.sv
      - hw/mem_arbiter.sv
      - hw/data_mem.sv
      - hw/lsq_top.sv
  - target: simulation
    files:
      - tests/tb_lsq_top.sv
